// File: l2cache_defs.svh
`ifndef L2CACHE_DEFS_SVH
`define L2CACHE_DEFS_SVH

// byte address width
`define L2_ADDR_BITS 32

// one cache line, as moved on both sides
`define L2_LINE_BITS 256

// byte offset within a line, 32 bytes per line
`define L2_OFFSET_BITS 5

// set index width, 16 sets
`define L2_SET_BITS 4

`endif

// File: l2cache_pkg.sv
`default_nettype none

`include "l2cache_defs.svh"

package l2cache_pkg;

    // tag is whatever is left above index and offset
    localparam int tag_bits = `L2_ADDR_BITS - `L2_OFFSET_BITS - `L2_SET_BITS;

    typedef logic [`L2_ADDR_BITS-1:0] addr_t;
    typedef logic [`L2_LINE_BITS-1:0] line_t;
    typedef logic [tag_bits-1:0]      tag_t;
    typedef logic [`L2_SET_BITS-1:0]  idx_t;

    // controller states
    typedef enum logic [1:0] {
        check,
        write_back,
        fill
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: l2cache_array.sv
`timescale 1ns/100ps
`default_nettype none

module l2cache_array #(
    parameter type entry_t = logic
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     write,
    input  wire l2cache_pkg::idx_t  index,
    input  wire entry_t             datain,
    output entry_t                  dataout
);
    import l2cache_pkg::*;

    localparam int num_sets = 2 ** $bits(idx_t);

    // one entry per set
    entry_t entries [num_sets];

    // everything starts out zero: invalid, clean, lru at way 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_sets; i++) begin
                entries[i] <= '0;
            end
        end else if (write) begin
            entries[index] <= datain;
        end
    end

    // read is combinational so a hit can answer in the same cycle
    assign dataout = entries[index];

endmodule

`default_nettype wire

// File: l2cache_datapath.sv
`timescale 1ns/100ps
`default_nettype none

`include "l2cache_defs.svh"

module l2cache_datapath (
    input  wire                     clk,
    input  wire                     rst_n,
    // upper-level side
    input  wire l2cache_pkg::addr_t mem_address,
    input  wire l2cache_pkg::line_t mem_wdata,
    output l2cache_pkg::line_t      mem_rdata,
    // physical memory side
    output l2cache_pkg::addr_t      pmem_address,
    output l2cache_pkg::line_t      pmem_wdata,
    input  wire l2cache_pkg::line_t pmem_rdata,
    // from control
    input  wire                     way_sel_method,
    input  wire                     load_line_data,
    input  wire                     load_valid,
    input  wire                     load_dirty,
    input  wire                     load_lru,
    input  wire                     load_wdata_reg,
    input  wire                     line_datain_sel,
    input  wire                     valid_in,
    input  wire                     dirty_in,
    input  wire                     address_sel,
    // to control
    output logic                    hit,
    output logic                    dirty,
    output logic                    valid
);
    import l2cache_pkg::*;

    tag_t       req_tag;
    idx_t       req_idx;
    addr_t      aligned_addr;
    addr_t      victim_addr;
    tag_t       victim_tag;

    line_t      data_out [2];
    tag_t       tag_out [2];
    logic [1:0] valid_out;
    logic [1:0] dirty_out;
    logic [1:0] hit_way;
    logic       lru_out;
    logic       lru_next;

    logic       way_select;
    logic [1:0] way_onehot;
    logic [1:0] load_data_way;
    logic [1:0] load_valid_way;
    logic [1:0] load_dirty_way;

    line_t      line_datain;
    line_t      lru_line;
    line_t      wb_line;

    // split the request address
    assign req_tag = mem_address[`L2_ADDR_BITS-1 -: $bits(tag_t)];
    assign req_idx = mem_address[`L2_OFFSET_BITS +: `L2_SET_BITS];

    // fill data comes from memory, write-hit data from the requester
    assign line_datain = line_datain_sel ? mem_wdata : pmem_rdata;

    for (genvar w = 0; w < 2; w++) begin : g_way
        l2cache_array #(.entry_t(line_t)) u_data (
            .clk     (clk),
            .rst_n   (rst_n),
            .write   (load_data_way[w]),
            .index   (req_idx),
            .datain  (line_datain),
            .dataout (data_out[w])
        );

        // tag follows the data strobe
        l2cache_array #(.entry_t(tag_t)) u_tag (
            .clk     (clk),
            .rst_n   (rst_n),
            .write   (load_data_way[w]),
            .index   (req_idx),
            .datain  (req_tag),
            .dataout (tag_out[w])
        );

        l2cache_array #(.entry_t(logic)) u_valid (
            .clk     (clk),
            .rst_n   (rst_n),
            .write   (load_valid_way[w]),
            .index   (req_idx),
            .datain  (valid_in),
            .dataout (valid_out[w])
        );

        l2cache_array #(.entry_t(logic)) u_dirty (
            .clk     (clk),
            .rst_n   (rst_n),
            .write   (load_dirty_way[w]),
            .index   (req_idx),
            .datain  (dirty_in),
            .dataout (dirty_out[w])
        );

        assign hit_way[w] = valid_out[w] && (tag_out[w] == req_tag);
    end

    // lru bit points at the way to evict next
    l2cache_array #(.entry_t(logic)) u_lru (
        .clk     (clk),
        .rst_n   (rst_n),
        .write   (load_lru),
        .index   (req_idx),
        .datain  (lru_next),
        .dataout (lru_out)
    );

    assign hit = |hit_way;

    // 0 picks the hit way, 1 picks the lru way
    assign way_select = way_sel_method ? lru_out : hit_way[1];
    assign way_onehot = way_select ? 2'b10 : 2'b01;
    assign lru_next   = ~way_select;

    // steer the load strobes to the chosen way
    assign load_data_way  = {2{load_line_data}} & way_onehot;
    assign load_valid_way = {2{load_valid}} & way_onehot;
    assign load_dirty_way = {2{load_dirty}} & way_onehot;

    assign mem_rdata = data_out[way_select];

    // status of the eviction candidate
    assign valid      = valid_out[lru_out];
    assign dirty      = dirty_out[lru_out];
    assign lru_line   = data_out[lru_out];
    assign victim_tag = tag_out[lru_out];

    // victim line held here while it goes out to memory
    always_ff @(posedge clk) begin
        if (load_wdata_reg) begin
            wb_line <= lru_line;
        end
    end

    assign pmem_wdata = wb_line;

    assign aligned_addr = {mem_address[`L2_ADDR_BITS-1:`L2_OFFSET_BITS],
                           {`L2_OFFSET_BITS{1'b0}}};
    assign victim_addr  = {victim_tag, req_idx, {`L2_OFFSET_BITS{1'b0}}};

    assign pmem_address = address_sel ? victim_addr : aligned_addr;

endmodule

`default_nettype wire

// File: l2cache_control.sv
`timescale 1ns/100ps
`default_nettype none

module l2cache_control (
    input  wire  clk,
    input  wire  rst_n,
    // upper-level request
    input  wire  mem_read,
    input  wire  mem_write,
    output logic mem_resp,
    // physical memory handshake
    input  wire  pmem_resp,
    output logic pmem_read,
    output logic pmem_write,
    // datapath status
    input  wire  hit,
    input  wire  dirty,
    input  wire  valid,
    // datapath control
    output logic way_sel_method,
    output logic load_line_data,
    output logic load_valid,
    output logic load_dirty,
    output logic load_lru,
    output logic load_wdata_reg,
    output logic line_datain_sel,
    output logic valid_in,
    output logic dirty_in,
    output logic address_sel
);
    import l2cache_pkg::*;

    // way select encodings
    localparam logic sel_hit = 1'b0;
    localparam logic sel_lru = 1'b1;

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        req;
    logic        victim_dirty;

    assign req          = mem_read || mem_write;
    assign victim_dirty = valid && dirty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= check;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            check: begin
                if (req && !hit) begin
                    next_state = victim_dirty ? write_back : fill;
                end
            end
            write_back: begin
                if (pmem_resp) begin
                    next_state = fill;
                end
            end
            fill: begin
                // back to check, which then hits
                if (pmem_resp) begin
                    next_state = check;
                end
            end
            default: next_state = check;
        endcase
    end

    always_comb begin
        mem_resp        = 1'b0;
        pmem_read       = 1'b0;
        pmem_write      = 1'b0;
        way_sel_method  = sel_hit;
        load_line_data  = 1'b0;
        load_valid      = 1'b0;
        load_dirty      = 1'b0;
        load_lru        = 1'b0;
        load_wdata_reg  = 1'b0;
        line_datain_sel = 1'b0;
        valid_in        = 1'b0;
        dirty_in        = 1'b0;
        address_sel     = 1'b0;
        case (state)
            check: begin
                if (req && hit) begin
                    mem_resp = 1'b1;
                    // other way becomes lru
                    load_lru = 1'b1;
                    if (mem_write) begin
                        load_line_data  = 1'b1;
                        line_datain_sel = 1'b1;
                        load_dirty      = 1'b1;
                        dirty_in        = 1'b1;
                    end
                end else if (req) begin
                    way_sel_method = sel_lru;
                    // grab the victim before it is overwritten
                    load_wdata_reg = victim_dirty;
                end
            end
            write_back: begin
                way_sel_method = sel_lru;
                address_sel    = 1'b1;
                pmem_write     = 1'b1;
            end
            fill: begin
                way_sel_method = sel_lru;
                pmem_read      = 1'b1;
                if (pmem_resp) begin
                    load_line_data = 1'b1;
                    load_valid     = 1'b1;
                    valid_in       = 1'b1;
                    load_dirty     = 1'b1;
                    dirty_in       = 1'b0;
                end
            end
            default: begin
                way_sel_method = sel_hit;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: l2cache.sv
`timescale 1ns/100ps
`default_nettype none

module l2cache (
    input  wire                     clk,
    input  wire                     rst_n,
    // upper-level side
    input  wire                     mem_read,
    input  wire                     mem_write,
    input  wire l2cache_pkg::addr_t mem_address,
    input  wire l2cache_pkg::line_t mem_wdata,
    output l2cache_pkg::line_t      mem_rdata,
    output logic                    mem_resp,
    // physical memory side
    output logic                    pmem_read,
    output logic                    pmem_write,
    output l2cache_pkg::addr_t      pmem_address,
    output l2cache_pkg::line_t      pmem_wdata,
    input  wire l2cache_pkg::line_t pmem_rdata,
    input  wire                     pmem_resp
);
    // control to datapath
    logic way_sel_method;
    logic load_line_data;
    logic load_valid;
    logic load_dirty;
    logic load_lru;
    logic load_wdata_reg;
    logic line_datain_sel;
    logic valid_in;
    logic dirty_in;
    logic address_sel;

    // datapath status back to control
    logic hit;
    logic dirty;
    logic valid;

    l2cache_control u_control (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_resp        (mem_resp),
        .pmem_resp       (pmem_resp),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .hit             (hit),
        .dirty           (dirty),
        .valid           (valid),
        .way_sel_method  (way_sel_method),
        .load_line_data  (load_line_data),
        .load_valid      (load_valid),
        .load_dirty      (load_dirty),
        .load_lru        (load_lru),
        .load_wdata_reg  (load_wdata_reg),
        .line_datain_sel (line_datain_sel),
        .valid_in        (valid_in),
        .dirty_in        (dirty_in),
        .address_sel     (address_sel)
    );

    l2cache_datapath u_datapath (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata),
        .pmem_address    (pmem_address),
        .pmem_wdata      (pmem_wdata),
        .pmem_rdata      (pmem_rdata),
        .way_sel_method  (way_sel_method),
        .load_line_data  (load_line_data),
        .load_valid      (load_valid),
        .load_dirty      (load_dirty),
        .load_lru        (load_lru),
        .load_wdata_reg  (load_wdata_reg),
        .line_datain_sel (line_datain_sel),
        .valid_in        (valid_in),
        .dirty_in        (dirty_in),
        .address_sel     (address_sel),
        .hit             (hit),
        .dirty           (dirty),
        .valid           (valid)
    );

endmodule

`default_nettype wire

// File: l2cache_checker.sv
`timescale 1ns/100ps
`default_nettype none

module l2cache_checker (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     mem_read,
    input  wire                     mem_write,
    input  wire l2cache_pkg::addr_t mem_address,
    input  wire l2cache_pkg::line_t mem_wdata,
    input  wire l2cache_pkg::line_t mem_rdata,
    input  wire                     mem_resp,
    input  wire                     pmem_read,
    input  wire                     pmem_write,
    input  wire l2cache_pkg::addr_t pmem_address,
    input  wire l2cache_pkg::line_t pmem_wdata,
    input  wire                     pmem_resp,
    output int                      data_errors,
    output int                      traffic_errors
);
    import l2cache_pkg::*;

    // latest contents of every line the requester has written
    line_t golden [addr_t];
    string test_name;
    int    pmem_reads;
    int    pmem_writes;

    initial begin
        test_name      = "reset";
        data_errors    = 0;
        traffic_errors = 0;
        pmem_reads     = 0;
        pmem_writes    = 0;
    end

    function automatic addr_t line_addr(input addr_t a);
        return {a[31:5], 5'd0};
    endfunction

    // contents of a line nobody has written yet
    function automatic line_t line_pattern(input addr_t a);
        line_t p;
        for (int i = 0; i < 8; i++) begin
            p[i*32 +: 32] = a ^ (32'h3c5a_96e1 + i * 32'h0101_0101);
        end
        return p;
    endfunction

    // reference model: last write to the line, else its pattern
    function automatic line_t expected_line(input addr_t a);
        if (golden.exists(line_addr(a))) begin
            return golden[line_addr(a)];
        end
        return line_pattern(line_addr(a));
    endfunction

    task automatic start_test(input string name);
        test_name   = name;
        pmem_reads  = 0;
        pmem_writes = 0;
    endtask

    task automatic check_traffic(input int exp_reads, input int exp_writes);
        if (pmem_reads != exp_reads) begin
            $display("** Error [%s] physical reads: expected %0d, actual %0d",
                     test_name, exp_reads, pmem_reads);
            traffic_errors++;
        end
        if (pmem_writes != exp_writes) begin
            $display("** Error [%s] physical writes: expected %0d, actual %0d",
                     test_name, exp_writes, pmem_writes);
            traffic_errors++;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (mem_resp && mem_read && mem_rdata !== expected_line(mem_address)) begin
                $display("** Error [%s] read of %h: expected %h, actual %h",
                         test_name, mem_address, expected_line(mem_address), mem_rdata);
                data_errors++;
            end
            if (mem_resp && mem_write) begin
                golden[line_addr(mem_address)] = mem_wdata;
            end
            if ((pmem_read || pmem_write) && pmem_address[4:0] != 5'd0) begin
                $display("** Error [%s] physical address %h is not line aligned",
                         test_name, pmem_address);
                traffic_errors++;
            end
            if (pmem_resp && pmem_read) begin
                pmem_reads++;
            end
            // a write-back must carry the newest data of its line
            if (pmem_resp && pmem_write) begin
                pmem_writes++;
                if (pmem_wdata !== expected_line(pmem_address)) begin
                    $display("** Error [%s] write-back to %h: expected %h, actual %h",
                             test_name, pmem_address, expected_line(pmem_address),
                             pmem_wdata);
                    data_errors++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_l2cache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_l2cache;
    import l2cache_pkg::*;

    localparam int req_timeout = 200;
    localparam int random_ops  = 300;

    logic   clk;
    logic   rst_n;
    logic   mem_read;
    logic   mem_write;
    addr_t  mem_address;
    line_t  mem_wdata;
    line_t  mem_rdata;
    logic   mem_resp;
    logic   pmem_read;
    logic   pmem_write;
    addr_t  pmem_address;
    line_t  pmem_wdata;
    line_t  pmem_rdata;
    logic   pmem_resp;

    integer seed;
    int     timeouts;
    int     data_errors;
    int     traffic_errors;
    int     delay_left;
    logic   mem_busy;
    line_t  pmem_store [addr_t];

    l2cache u_l2cache (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    l2cache_checker u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_address    (mem_address),
        .mem_wdata      (mem_wdata),
        .mem_rdata      (mem_rdata),
        .mem_resp       (mem_resp),
        .pmem_read      (pmem_read),
        .pmem_write     (pmem_write),
        .pmem_address   (pmem_address),
        .pmem_wdata     (pmem_wdata),
        .pmem_resp      (pmem_resp),
        .data_errors    (data_errors),
        .traffic_errors (traffic_errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // memory picks its delay when a new request shows up
    always @(posedge clk) begin
        if (rst_n && (pmem_read || pmem_write) && !mem_busy && !pmem_resp) begin
            mem_busy   = 1'b1;
            delay_left = $unsigned($random(seed)) % 6;
        end
    end

    // memory answers on the falling edge
    always @(negedge clk) begin
        pmem_resp = 1'b0;
        if (mem_busy && delay_left == 0) begin
            mem_busy  = 1'b0;
            pmem_resp = 1'b1;
            if (pmem_write) begin
                pmem_store[pmem_address] = pmem_wdata;
            end else if (pmem_store.exists(pmem_address)) begin
                pmem_rdata = pmem_store[pmem_address];
            end else begin
                pmem_rdata = u_checker.line_pattern(pmem_address);
            end
        end else if (mem_busy) begin
            delay_left--;
        end
    end

    function automatic addr_t make_addr(input tag_t tag, input idx_t idx,
                                        input logic [4:0] off);
        return {tag, idx, off};
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int i = 0; i < 8; i++) begin
            l[i*32 +: 32] = $random(seed);
        end
        return l;
    endfunction

    task automatic finish_run();
        $display("errors: data %0d, traffic %0d, timeouts %0d",
                 data_errors, traffic_errors, timeouts);
        if (data_errors + traffic_errors + timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    // hold the request until mem_resp, then drop it
    task automatic run_request(input logic wr, input addr_t addr, input line_t data);
        int waited;
        waited      = 0;
        mem_read    = !wr;
        mem_write   = wr;
        mem_address = addr;
        mem_wdata   = data;
        do begin
            @(posedge clk);
            waited++;
        end while (!mem_resp && waited < req_timeout);
        if (!mem_resp) begin
            $display("timeout: the cache never responded to the request at %h", addr);
            timeouts++;
        end
        @(negedge clk);
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    initial begin
        addr_t a;
        line_t d;
        int    tag_n;
        int    set_n;
        logic  wr;
        seed        = 32'h9211_1f55;
        timeouts    = 0;
        mem_busy    = 1'b0;
        delay_left  = 0;
        rst_n       = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_address = '0;
        mem_wdata   = '0;
        pmem_rdata  = '0;
        pmem_resp   = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        u_checker.start_test("read miss then fill");
        a = make_addr(23'h01234, 4'd1, 5'd8);
        run_request(1'b0, a, '0);
        u_checker.check_traffic(1, 0);

        u_checker.start_test("read hit");
        run_request(1'b0, a, '0);
        u_checker.check_traffic(0, 0);

        u_checker.start_test("write then read");
        d = random_line();
        run_request(1'b1, a, d);
        run_request(1'b0, a, '0);
        u_checker.check_traffic(0, 0);

        // two dirty tags, then a third pushes the older one out
        u_checker.start_test("dirty eviction");
        d = random_line();
        run_request(1'b1, make_addr(23'h00011, 4'd2, 5'd0), d);
        d = random_line();
        run_request(1'b1, make_addr(23'h00022, 4'd2, 5'd4), d);
        run_request(1'b0, make_addr(23'h00033, 4'd2, 5'd0), '0);
        u_checker.check_traffic(3, 1);
        run_request(1'b0, make_addr(23'h00011, 4'd2, 5'd16), '0);
        u_checker.check_traffic(4, 2);

        u_checker.start_test("clean eviction");
        for (int t = 0; t < 3; t++) begin
            run_request(1'b0, make_addr(tag_t'(32'h44 + t), 4'd3, 5'd0), '0);
        end
        u_checker.check_traffic(3, 0);

        // sets 8 to 11 with six tags each
        u_checker.start_test("random mix");
        for (int n = 0; n < random_ops; n++) begin
            tag_n = $unsigned($random(seed)) % 6;
            set_n = $unsigned($random(seed)) % 4;
            wr    = 1'($random(seed));
            d     = random_line();
            a     = make_addr(tag_t'(32'h200 + 32'h1357 * tag_n), idx_t'(8 + set_n), 5'(n));
            run_request(wr, a, d);
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
l2cache_pkg.sv
l2cache_array.sv
l2cache_datapath.sv
l2cache_control.sv
l2cache.sv
l2cache_checker.sv
tb_l2cache.sv
